/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// boot vector of the core
`define FETCH_RESET_PC 32'h1C00_0000

`define FETCH_ADDR_W 32

// one aligned instruction pair per fetch
`define FETCH_STEP 8

// window segment = top address bits
`define SEG_W 3

// fetch exception codes
`define ECODE_NONE 6'd0
`define ECODE_ADEF 6'd8
`define ECODE_MISS 6'd63   // mapped address outside both windows

`endif

/* mmu_pkg.sv */
`include "fetch_settings.svh"

package mmu_pkg;

    // privilege level, 0 kernel, 3 user
    typedef logic [1:0] plv_t;

    // memory access type
    typedef logic [1:0] mat_t;

    // top address bits matched by a direct-mapped window
    typedef logic [`SEG_W-1:0] seg_t;

    // 1 = direct, 0 = mapped
    typedef logic xmode_t;

    localparam plv_t PLV_KERNEL = 2'd0;
    localparam plv_t PLV_USER = 2'd3;

    localparam mat_t MAT_SUC = 2'd0;   // strongly-ordered uncached

    localparam xmode_t XMODE_DIRECT = 1'b1;

endpackage

/* fetch_pkg.sv */
`include "fetch_settings.svh"

package fetch_pkg;

    // virtual fetch address, as held in the PC
    typedef logic [`FETCH_ADDR_W-1:0] vaddr_t;

    // physical fetch address after window translation
    typedef logic [`FETCH_ADDR_W-1:0] paddr_t;

    typedef logic [5:0] ecode_t;

    // one bit per redirect source, any set bit flushes the front end
    typedef logic [4:0] redir_src_t;

    // bit positions in redir_src_t, higher index wins
    localparam int RS_PRE = 0;      // predecoder correction
    localparam int RS_BR = 1;       // branch resolution
    localparam int RS_CSR = 2;      // csr write flush
    localparam int RS_ERA = 3;      // exception return
    localparam int RS_EENTRY = 4;   // exception entry

endpackage

/* pc_gen.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module pc_gen (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_stall,
    input  logic              i_eentry_en,
    input  fetch_pkg::vaddr_t i_eentry_pc,
    input  logic              i_era_en,
    input  fetch_pkg::vaddr_t i_era_pc,
    input  logic              i_csr_flush,
    input  fetch_pkg::vaddr_t i_csr_flush_pc,
    input  logic              i_br_redirect,
    input  fetch_pkg::vaddr_t i_br_pc,
    input  logic              i_pre_redirect,
    input  fetch_pkg::vaddr_t i_pre_pc,
    output fetch_pkg::vaddr_t o_pc,
    output logic              o_flush
);
    import fetch_pkg::*;

    redir_src_t src;
    vaddr_t     pc_q;
    vaddr_t     pc_next;
    logic       pc_upd;

    // gather strobes, bit order follows priority
    always_comb begin
        src = '0;
        src[RS_EENTRY] = i_eentry_en;
        src[RS_ERA] = i_era_en;
        src[RS_CSR] = i_csr_flush;
        src[RS_BR] = i_br_redirect;
        src[RS_PRE] = i_pre_redirect;
    end

    assign o_flush = |src;

    // highest-priority target, else next pair
    always_comb begin
        if (src[RS_EENTRY]) begin
            pc_next = i_eentry_pc;
        end else if (src[RS_ERA]) begin
            pc_next = i_era_pc;
        end else if (src[RS_CSR]) begin
            pc_next = i_csr_flush_pc;
        end else if (src[RS_BR]) begin
            pc_next = i_br_pc;
        end else if (src[RS_PRE]) begin
            pc_next = i_pre_pc;
        end else begin
            pc_next = pc_q + vaddr_t'(`FETCH_STEP);
        end
    end

    // a redirect always lands, even under back-pressure
    assign pc_upd = o_flush | ~i_stall;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= vaddr_t'(`FETCH_RESET_PC);
        end else if (pc_upd) begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;   // IF1 address

endmodule

/* dmw_translate.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module dmw_translate (
    input  fetch_pkg::vaddr_t i_vaddr,
    input  mmu_pkg::plv_t     i_plv,
    input  mmu_pkg::xmode_t   i_xmode,
    input  mmu_pkg::mat_t     i_direct_mat,
    input  logic              i_dmw0_plv0,
    input  logic              i_dmw0_plv3,
    input  mmu_pkg::mat_t     i_dmw0_mat,
    input  mmu_pkg::seg_t     i_dmw0_vseg,
    input  mmu_pkg::seg_t     i_dmw0_pseg,
    input  logic              i_dmw1_plv0,
    input  logic              i_dmw1_plv3,
    input  mmu_pkg::mat_t     i_dmw1_mat,
    input  mmu_pkg::seg_t     i_dmw1_vseg,
    input  mmu_pkg::seg_t     i_dmw1_pseg,
    output fetch_pkg::paddr_t o_paddr,
    output logic              o_uncache,
    output logic              o_hit
);
    import mmu_pkg::*;
    import fetch_pkg::*;

    localparam int LOW_W = `FETCH_ADDR_W - `SEG_W;

    seg_t             vseg;
    logic [LOW_W-1:0] offset;
    logic             dmw0_hit;
    logic             dmw1_hit;

    // segment match plus enable for the current level
    function automatic logic win_hit(
        input seg_t win_vseg,
        input logic en_plv0,
        input logic en_plv3,
        input seg_t addr_seg,
        input plv_t cur_plv
    );
        logic lvl_ok;
        lvl_ok = (cur_plv == PLV_KERNEL && en_plv0) || (cur_plv == PLV_USER && en_plv3);
        return (win_vseg == addr_seg) && lvl_ok;
    endfunction

    assign vseg = i_vaddr[`FETCH_ADDR_W-1 -: `SEG_W];
    assign offset = i_vaddr[LOW_W-1:0];

    assign dmw0_hit = win_hit(i_dmw0_vseg, i_dmw0_plv0, i_dmw0_plv3, vseg, i_plv);
    assign dmw1_hit = win_hit(i_dmw1_vseg, i_dmw1_plv0, i_dmw1_plv3, vseg, i_plv);

    always_comb begin
        if (i_xmode == XMODE_DIRECT) begin
            o_paddr = paddr_t'(i_vaddr);
            o_uncache = (i_direct_mat == MAT_SUC);
            o_hit = 1'b1;
        end else if (dmw0_hit) begin   // window 0 wins on overlap
            o_paddr = {i_dmw0_pseg, offset};
            o_uncache = (i_dmw0_mat == MAT_SUC);
            o_hit = 1'b1;
        end else if (dmw1_hit) begin
            o_paddr = {i_dmw1_pseg, offset};
            o_uncache = (i_dmw1_mat == MAT_SUC);
            o_hit = 1'b1;
        end else begin
            // would go to a TLB, here only flagged
            o_paddr = paddr_t'(i_vaddr);
            o_uncache = 1'b1;
            o_hit = 1'b0;
        end
    end

endmodule

/* fetch_pipe.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_pipe (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_stall,
    input  logic              i_flush,
    input  fetch_pkg::vaddr_t i_pc,
    input  fetch_pkg::paddr_t i_paddr,
    input  logic              i_uncache,
    input  logic              i_hit,
    output logic              o_valid,
    output fetch_pkg::vaddr_t o_pc,
    output fetch_pkg::paddr_t o_paddr,
    output logic              o_uncache,
    output fetch_pkg::ecode_t o_ecode
);
    import fetch_pkg::*;

    logic   capture;
    ecode_t ecode_if1;

    logic   valid_q;
    vaddr_t pc_q;
    paddr_t paddr_q;
    logic   uncache_q;
    ecode_t ecode_q;

    // flush overrides stall, same rule as the PC register
    assign capture = i_flush | ~i_stall;

    // misalignment is checked before the window result
    always_comb begin
        if (i_pc[1:0] != 2'b00) begin
            ecode_if1 = `ECODE_ADEF;
        end else if (!i_hit) begin
            ecode_if1 = `ECODE_MISS;
        end else begin
            ecode_if1 = `ECODE_NONE;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;   // fetch in IF1 is on the wrong path
        end else if (!i_stall) begin
            valid_q <= 1'b1;
        end
    end

    // payload follows capture, valid decides whether it counts
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= '0;
            paddr_q <= '0;
            uncache_q <= 1'b0;
            ecode_q <= `ECODE_NONE;
        end else if (capture) begin
            pc_q <= i_pc;
            paddr_q <= i_paddr;
            uncache_q <= i_uncache;
            ecode_q <= ecode_if1;
        end
    end

    assign o_valid = valid_q;
    assign o_pc = pc_q;
    assign o_paddr = paddr_q;
    assign o_uncache = uncache_q;
    assign o_ecode = ecode_q;

endmodule

/* fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_stall,
    input  logic              i_eentry_en,
    input  fetch_pkg::vaddr_t i_eentry_pc,
    input  logic              i_era_en,
    input  fetch_pkg::vaddr_t i_era_pc,
    input  logic              i_csr_flush,
    input  fetch_pkg::vaddr_t i_csr_flush_pc,
    input  logic              i_br_redirect,
    input  fetch_pkg::vaddr_t i_br_pc,
    input  logic              i_pre_redirect,
    input  fetch_pkg::vaddr_t i_pre_pc,
    input  mmu_pkg::plv_t     i_plv,
    input  mmu_pkg::xmode_t   i_xmode,
    input  mmu_pkg::mat_t     i_direct_mat,
    input  logic              i_dmw0_plv0,
    input  logic              i_dmw0_plv3,
    input  mmu_pkg::mat_t     i_dmw0_mat,
    input  mmu_pkg::seg_t     i_dmw0_vseg,
    input  mmu_pkg::seg_t     i_dmw0_pseg,
    input  logic              i_dmw1_plv0,
    input  logic              i_dmw1_plv3,
    input  mmu_pkg::mat_t     i_dmw1_mat,
    input  mmu_pkg::seg_t     i_dmw1_vseg,
    input  mmu_pkg::seg_t     i_dmw1_pseg,
    output logic              o_fetch_valid,
    output fetch_pkg::vaddr_t o_fetch_pc,
    output fetch_pkg::paddr_t o_fetch_paddr,
    output logic              o_fetch_uncache,
    output fetch_pkg::ecode_t o_fetch_ecode
);
    import fetch_pkg::*;

    vaddr_t pc_if1;
    logic   flush_if1;
    paddr_t paddr_if1;
    logic   uncache_if1;
    logic   hit_if1;

    pc_gen pc_gen_inst (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_stall        (i_stall),
        .i_eentry_en    (i_eentry_en),
        .i_eentry_pc    (i_eentry_pc),
        .i_era_en       (i_era_en),
        .i_era_pc       (i_era_pc),
        .i_csr_flush    (i_csr_flush),
        .i_csr_flush_pc (i_csr_flush_pc),
        .i_br_redirect  (i_br_redirect),
        .i_br_pc        (i_br_pc),
        .i_pre_redirect (i_pre_redirect),
        .i_pre_pc       (i_pre_pc),
        .o_pc           (pc_if1),
        .o_flush        (flush_if1)
    );

    // same-cycle translation of the IF1 PC
    dmw_translate dmw_translate_inst (
        .i_vaddr      (pc_if1),
        .i_plv        (i_plv),
        .i_xmode      (i_xmode),
        .i_direct_mat (i_direct_mat),
        .i_dmw0_plv0  (i_dmw0_plv0),
        .i_dmw0_plv3  (i_dmw0_plv3),
        .i_dmw0_mat   (i_dmw0_mat),
        .i_dmw0_vseg  (i_dmw0_vseg),
        .i_dmw0_pseg  (i_dmw0_pseg),
        .i_dmw1_plv0  (i_dmw1_plv0),
        .i_dmw1_plv3  (i_dmw1_plv3),
        .i_dmw1_mat   (i_dmw1_mat),
        .i_dmw1_vseg  (i_dmw1_vseg),
        .i_dmw1_pseg  (i_dmw1_pseg),
        .o_paddr      (paddr_if1),
        .o_uncache    (uncache_if1),
        .o_hit        (hit_if1)
    );

    fetch_pipe fetch_pipe_inst (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_stall   (i_stall),
        .i_flush   (flush_if1),
        .i_pc      (pc_if1),
        .i_paddr   (paddr_if1),
        .i_uncache (uncache_if1),
        .i_hit     (hit_if1),
        .o_valid   (o_fetch_valid),
        .o_pc      (o_fetch_pc),
        .o_paddr   (o_fetch_paddr),
        .o_uncache (o_fetch_uncache),
        .o_ecode   (o_fetch_ecode)
    );

endmodule

/* tb_fetch.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"

module tb_fetch;
    import mmu_pkg::*;
    import fetch_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES = 2000;
    localparam int PHASE_CYCLES = 200;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 10;   // 10 % margin

    logic   clk;
    logic   arst_n;
    logic   stall;
    logic   eentry_en;
    vaddr_t eentry_pc;
    logic   era_en;
    vaddr_t era_pc;
    logic   csr_flush;
    vaddr_t csr_flush_pc;
    logic   br_redirect;
    vaddr_t br_pc;
    logic   pre_redirect;
    vaddr_t pre_pc;
    plv_t   plv;
    xmode_t xmode;
    mat_t   direct_mat;
    logic   dmw0_plv0;
    logic   dmw0_plv3;
    mat_t   dmw0_mat;
    seg_t   dmw0_vseg;
    seg_t   dmw0_pseg;
    logic   dmw1_plv0;
    logic   dmw1_plv3;
    mat_t   dmw1_mat;
    seg_t   dmw1_vseg;
    seg_t   dmw1_pseg;

    logic   fetch_valid;
    vaddr_t fetch_pc;
    paddr_t fetch_paddr;
    logic   fetch_uncache;
    ecode_t fetch_ecode;

    // reference model state
    vaddr_t m_pc_if1;
    logic   m_valid;
    vaddr_t m_pc;
    paddr_t m_paddr;
    logic   m_uncache;
    ecode_t m_ecode;
    logic   m_hold;   // last edge was a plain stall

    // outputs seen one cycle earlier
    vaddr_t s_pc;
    paddr_t s_paddr;
    logic   s_uncache;
    ecode_t s_ecode;

    int n_multi;
    int n_stall_redirect;
    int n_hold;
    int n_direct;
    int n_window;
    int n_miss;
    int n_adef;
    int seed_val;

    fetch_top fetch_top_inst (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_stall        (stall),
        .i_eentry_en    (eentry_en),
        .i_eentry_pc    (eentry_pc),
        .i_era_en       (era_en),
        .i_era_pc       (era_pc),
        .i_csr_flush    (csr_flush),
        .i_csr_flush_pc (csr_flush_pc),
        .i_br_redirect  (br_redirect),
        .i_br_pc        (br_pc),
        .i_pre_redirect (pre_redirect),
        .i_pre_pc       (pre_pc),
        .i_plv          (plv),
        .i_xmode        (xmode),
        .i_direct_mat   (direct_mat),
        .i_dmw0_plv0    (dmw0_plv0),
        .i_dmw0_plv3    (dmw0_plv3),
        .i_dmw0_mat     (dmw0_mat),
        .i_dmw0_vseg    (dmw0_vseg),
        .i_dmw0_pseg    (dmw0_pseg),
        .i_dmw1_plv0    (dmw1_plv0),
        .i_dmw1_plv3    (dmw1_plv3),
        .i_dmw1_mat     (dmw1_mat),
        .i_dmw1_vseg    (dmw1_vseg),
        .i_dmw1_pseg    (dmw1_pseg),
        .o_fetch_valid  (fetch_valid),
        .o_fetch_pc     (fetch_pc),
        .o_fetch_paddr  (fetch_paddr),
        .o_fetch_uncache(fetch_uncache),
        .o_fetch_ecode  (fetch_ecode)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t ns: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    function automatic logic level_enabled(input logic en_kernel, input logic en_user);
        case (plv)
            2'd0: return en_kernel;
            2'd3: return en_user;
            default: return 1'b0;   // levels 1 and 2 never match a window
        endcase
    endfunction

    task automatic model_translate(input vaddr_t va, output paddr_t pa, output logic unc,
                                   output logic hit);
        seg_t top;
        logic win0;
        logic win1;
        top = va[`FETCH_ADDR_W-1 -: `SEG_W];
        win0 = (dmw0_vseg == top) && level_enabled(dmw0_plv0, dmw0_plv3);
        win1 = (dmw1_vseg == top) && level_enabled(dmw1_plv0, dmw1_plv3);
        pa = va;
        unc = 1'b1;
        hit = 1'b0;
        if (xmode == 1'b1) begin
            unc = (direct_mat == 2'd0);
            hit = 1'b1;
        end else if (win0) begin
            pa[`FETCH_ADDR_W-1 -: `SEG_W] = dmw0_pseg;
            unc = (dmw0_mat == 2'd0);
            hit = 1'b1;
        end else if (win1) begin
            pa[`FETCH_ADDR_W-1 -: `SEG_W] = dmw1_pseg;
            unc = (dmw1_mat == 2'd0);
            hit = 1'b1;
        end
    endtask

    // next IF1 pc from the strobes now on the inputs
    function automatic vaddr_t next_pc();
        if (eentry_en) return eentry_pc;
        if (era_en) return era_pc;
        if (csr_flush) return csr_flush_pc;
        if (br_redirect) return br_pc;
        if (pre_redirect) return pre_pc;
        return m_pc_if1 + `FETCH_STEP;
    endfunction

    task automatic step_model();
        int     n_strobe;
        paddr_t pa;
        logic   unc;
        logic   hit;
        n_strobe = 0;
        n_strobe += eentry_en;
        n_strobe += era_en;
        n_strobe += csr_flush;
        n_strobe += br_redirect;
        n_strobe += pre_redirect;
        s_pc = fetch_pc;
        s_paddr = fetch_paddr;
        s_uncache = fetch_uncache;
        s_ecode = fetch_ecode;
        m_hold = stall && (n_strobe == 0);
        if (n_strobe > 1) n_multi++;
        if (stall && n_strobe > 0) n_stall_redirect++;
        if (n_strobe > 0) begin
            m_valid = 1'b0;
            m_pc_if1 = next_pc();
        end else if (!stall) begin
            model_translate(m_pc_if1, pa, unc, hit);
            m_valid = 1'b1;
            m_pc = m_pc_if1;
            m_paddr = pa;
            m_uncache = unc;
            if (m_pc_if1[1:0] != 2'b00) begin
                m_ecode = `ECODE_ADEF;
                n_adef++;
            end else if (!hit) begin
                m_ecode = `ECODE_MISS;
                n_miss++;
            end else begin
                m_ecode = `ECODE_NONE;
            end
            if (xmode == 1'b1) n_direct++;
            else if (hit) n_window++;
            m_pc_if1 = next_pc();
        end
    endtask

    task automatic check_outputs();
        if (m_hold) n_hold++;
        check_value("o_fetch_valid", m_valid, fetch_valid);
        if (m_valid) begin
            check_value("o_fetch_pc", m_pc, fetch_pc);
            check_value("o_fetch_paddr", m_paddr, fetch_paddr);
            check_value("o_fetch_uncache", m_uncache, fetch_uncache);
            check_value("o_fetch_ecode", m_ecode, fetch_ecode);
        end else if (m_hold) begin
            // payload frozen by the stall even without a valid fetch
            check_value("o_fetch_pc (stall hold)", s_pc, fetch_pc);
            check_value("o_fetch_paddr (stall hold)", s_paddr, fetch_paddr);
            check_value("o_fetch_uncache (stall hold)", s_uncache, fetch_uncache);
            check_value("o_fetch_ecode (stall hold)", s_ecode, fetch_ecode);
        end
    endtask

    // about one target in eight misaligned
    function automatic vaddr_t random_target();
        vaddr_t t;
        t = vaddr_t'($urandom);
        if ($urandom % 8 == 0) begin
            t[1:0] = 2'd1 + 2'($urandom % 3);
        end else begin
            t[2:0] = 3'b000;
        end
        return t;
    endfunction

    task automatic randomize_config(input int phase);
        int   r;
        seg_t vs0;
        r = $urandom % 8;
        vs0 = seg_t'($urandom);
        if (phase == 0) xmode <= 1'b1;
        else if (phase == 1) xmode <= 1'b0;
        else xmode <= ($urandom % 3 == 0);
        case (r)
            0, 1, 2: plv <= 2'd0;
            3, 4, 5: plv <= 2'd3;
            6: plv <= 2'd1;
            default: plv <= 2'd2;
        endcase
        direct_mat <= mat_t'($urandom % 4);
        dmw0_plv0 <= ($urandom % 4 != 0);
        dmw0_plv3 <= ($urandom % 2 == 0);
        dmw0_mat <= mat_t'($urandom % 4);
        dmw0_vseg <= vs0;
        dmw0_pseg <= seg_t'($urandom);
        dmw1_plv0 <= ($urandom % 2 == 0);
        dmw1_plv3 <= ($urandom % 4 != 0);
        dmw1_mat <= mat_t'($urandom % 4);
        dmw1_vseg <= ($urandom % 4 == 0) ? vs0 : seg_t'($urandom);   // overlap now and then
        dmw1_pseg <= seg_t'($urandom);
    endtask

    task automatic drive_stimulus();
        logic burst;
        burst = ($urandom % 40 == 0);
        eentry_en <= burst ? ($urandom % 2 == 0) : ($urandom % 24 == 0);
        era_en <= burst ? ($urandom % 2 == 0) : ($urandom % 24 == 0);
        csr_flush <= burst ? ($urandom % 2 == 0) : ($urandom % 24 == 0);
        br_redirect <= burst ? ($urandom % 2 == 0) : ($urandom % 16 == 0);
        pre_redirect <= burst ? ($urandom % 2 == 0) : ($urandom % 16 == 0);
        eentry_pc <= random_target();
        era_pc <= random_target();
        csr_flush_pc <= random_target();
        br_pc <= random_target();
        pre_pc <= random_target();
        stall <= ($urandom % 4 == 0);
    endtask

    task automatic expect_covered(input logic covered, input string what);
        assert (covered) else begin
            $display("coverage gap: %s never happened", what);
            stop_on_failure();
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_on_failure();
    end

    initial begin
        seed_val = $urandom(3888);
        arst_n = 1'b0;
        stall = 1'b0;
        {eentry_en, era_en, csr_flush, br_redirect, pre_redirect} = '0;
        {eentry_pc, era_pc, csr_flush_pc, br_pc, pre_pc} = '0;
        plv = 2'd0;
        xmode = 1'b1;
        direct_mat = 2'd1;
        {dmw0_plv0, dmw0_plv3, dmw0_mat, dmw0_vseg, dmw0_pseg} = '0;
        {dmw1_plv0, dmw1_plv3, dmw1_mat, dmw1_vseg, dmw1_pseg} = '0;
        m_pc_if1 = `FETCH_RESET_PC;
        {m_valid, m_pc, m_paddr, m_uncache, m_ecode, m_hold} = '0;
        {n_multi, n_stall_redirect, n_hold, n_direct, n_window, n_miss, n_adef} = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("o_fetch_valid", 1'b0, fetch_valid);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_outputs();
        step_model();

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk);
            if (cyc % PHASE_CYCLES == 0) randomize_config(cyc / PHASE_CYCLES);
            drive_stimulus();
            @(negedge clk);
            check_outputs();
            step_model();
        end

        expect_covered(n_multi > 0, "several redirects in one cycle");
        expect_covered(n_stall_redirect > 0, "a redirect during a stall");
        expect_covered(n_hold > 0, "a stall without redirect");
        expect_covered(n_direct > 0, "a direct-mode fetch");
        expect_covered(n_window > 0, "a mapped fetch hitting a window");
        expect_covered(n_miss > 0, "a mapped fetch missing both windows");
        expect_covered(n_adef > 0, "a misaligned fetch");

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
mmu_pkg.sv
fetch_pkg.sv
pc_gen.sv
dmw_translate.sv
fetch_pipe.sv
fetch_top.sv
tb_fetch.sv
